//--- design/cfg_pkg.sv
/*
  Command and response formats of the configuration port.
  16 entries of 32 bits, entry 15 holds the control-and-status VN id (read-only).
  In a read command the low NODE_ID_W payload bits carry the requester's id.
  CMD_NOP and CMD_RSVD are accepted and have no effect.
*/
package cfg_pkg;

  // ------------------------------
  // register map
  // ------------------------------
  localparam int ENTRY_W      = 32;
  localparam int ENTRY_ID_W   = 4;
  localparam int NUM_ENTRIES  = 2 ** ENTRY_ID_W;
  localparam int NODE_ID_W    = 8;

  // control-and-status VN id lives here, never written by commands
  localparam int CSR_VN_ENTRY = 15;

  // ------------------------------
  // command stream
  // ------------------------------
  typedef enum logic [1:0] {
    CMD_NOP   = 2'd0,
    CMD_WRITE = 2'd1,
    CMD_READ  = 2'd2,
    CMD_RSVD  = 2'd3
  } cfg_opcode_e;

  // 38 bits, opcode on top
  typedef struct packed {
    cfg_opcode_e             opcode;
    logic [ENTRY_ID_W-1:0]   entry;
    // write data, or source id in the low bits for a read
    logic [ENTRY_W-1:0]      payload;
  } cfg_cmd_t;

  // ------------------------------
  // response stream
  // ------------------------------
  // 40 bits, source id on top so the router can steer it back
  typedef struct packed {
    logic [NODE_ID_W-1:0]    source_id;
    logic [ENTRY_W-1:0]      data;
  } cfg_rsp_t;

endpackage

//--- design/lbdr_pkg.sv
/*
  LBDR routing and connectivity bits of a 2D mesh node.
  Node ids grow east (x) and north (y): x is the low COORD_W id bits,
  y the next COORD_W bits. Defaults give XY routing, which is the same
  in every node; only the connectivity bits depend on mesh position.
*/
package lbdr_pkg;

  localparam int COORD_W = 4;
  localparam int LBDR_W  = 12;
  localparam int MAX_VNS = 8;

  // routing bits first, then connectivity, top bit down
  typedef struct packed {
    logic rne;
    logic rnw;
    logic ren;
    logic res;
    logic rwn;
    logic rws;
    logic rse;
    logic rsw;
    logic cn;
    logic ce;
    logic cw;
    logic cs;
  } lbdr_bits_t;

  // XY defaults for the node at node_id in a cols x rows mesh
  function automatic lbdr_bits_t lbdr_default(input int unsigned node_id,
                                              input int unsigned cols,
                                              input int unsigned rows);
    logic [31:0] id_vec;
    int unsigned x;
    int unsigned y;
    lbdr_bits_t  bits;
    id_vec = node_id;
    x      = 32'(id_vec[COORD_W-1:0]);
    y      = 32'(id_vec[2*COORD_W-1:COORD_W]);
    bits   = '0;
    // xy: leave x first, turns only from east/west onto north/south
    bits.ren = 1'b1;
    bits.res = 1'b1;
    bits.rwn = 1'b1;
    bits.rws = 1'b1;
    // no link off the mesh edge
    bits.cw  = (x != 0);
    bits.ce  = (x != cols - 1);
    bits.cs  = (y != 0);
    bits.cn  = (y != rows - 1);
    return bits;
  endfunction

endpackage

//--- design/cfg_cmd_decoder.sv
/*
  Command side of the register bank, purely combinational.
  Only a read waits while a response is stalled; writes and no-ops
  are always accepted. Strobes are single-cycle, one per transfer.
*/
module cfg_cmd_decoder
  import cfg_pkg::*;
(
  input  logic                  cmd_valid_i,
  input  cfg_cmd_t              cmd_data_i,
  input  logic                  rsp_stall_i,
  output logic                  cmd_ready_o,
  output logic                  wr_en_o,
  output logic                  rd_en_o,
  output logic [ENTRY_ID_W-1:0] entry_o,
  output logic [ENTRY_W-1:0]    payload_o
);

  logic is_read;
  logic accept;

  // ------------------------------
  // readiness
  // ------------------------------
  assign is_read = (cmd_data_i.opcode == CMD_READ);

  // a second read has nowhere to go while the held response is stuck
  assign cmd_ready_o = !(rsp_stall_i && is_read);

  // valid/ready transfer this cycle
  assign accept = cmd_valid_i && cmd_ready_o;

  // ------------------------------
  // strobes
  // ------------------------------
  always_comb begin
    wr_en_o = 1'b0;
    rd_en_o = 1'b0;
    if (accept) begin
      case (cmd_data_i.opcode)
        CMD_WRITE: wr_en_o = 1'b1;
        CMD_READ:  rd_en_o = 1'b1;
        // nop and reserved are consumed silently
        default: begin
        end
      endcase
    end
  end

  // fields go straight to bank and response buffer
  assign entry_o   = cmd_data_i.entry;
  assign payload_o = cmd_data_i.payload;

endmodule

//--- design/cfg_register_bank.sv
/*
  Register array of the configuration bank.
  Entries 0..NUM_VNS-1 hold LBDR bits per VN and drive lbdr_bits_o.
  Reset loads XY defaults there, CSR_VN_ID into the CSR entry, zero elsewhere.
  Writes to CSR_VN_ENTRY are dropped. Reads are combinational, so a read
  sees the value before a write at the same edge.
*/
module cfg_register_bank
  import cfg_pkg::*, lbdr_pkg::*;
#(
  parameter int unsigned NODE_ID   = 0,
  parameter int unsigned MESH_COLS = 1,
  parameter int unsigned MESH_ROWS = 1,
  parameter int unsigned NUM_VNS   = 1,
  parameter int unsigned CSR_VN_ID = 0
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        wr_en_i,
  input  logic [ENTRY_ID_W-1:0]       entry_i,
  input  logic [ENTRY_W-1:0]          payload_i,
  output logic [ENTRY_W-1:0]          rd_data_o,
  output lbdr_bits_t [NUM_VNS-1:0]    lbdr_bits_o
);

  // ------------------------------
  // reset values
  // ------------------------------
  localparam lbdr_bits_t LBDR_RST = lbdr_default(NODE_ID, MESH_COLS, MESH_ROWS);

  // zero-extended to a full entry
  localparam logic [ENTRY_W-1:0] VN_ENTRY_RST  = {{(ENTRY_W-LBDR_W){1'b0}}, LBDR_RST};
  localparam logic [ENTRY_W-1:0] CSR_ENTRY_RST = ENTRY_W'(CSR_VN_ID);

  logic [ENTRY_W-1:0] regs_q [NUM_ENTRIES];
  logic               wr_allowed;

  // csr entry is read-only from the port
  assign wr_allowed = wr_en_i && (entry_i != ENTRY_ID_W'(CSR_VN_ENTRY));

  // ------------------------------
  // register array
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (i < NUM_VNS) begin
          regs_q[i] <= VN_ENTRY_RST;
        end else if (i == CSR_VN_ENTRY) begin
          regs_q[i] <= CSR_ENTRY_RST;
        end else begin
          regs_q[i] <= '0;
        end
      end
    end else if (wr_allowed) begin
      regs_q[entry_i] <= payload_i;
    end
  end

  // read port, addressed by the command currently on the stream
  assign rd_data_o = regs_q[entry_i];

  // ------------------------------
  // lbdr outputs
  // ------------------------------
  // only the low LBDR_W bits matter to the router, upper bits are free storage
  for (genvar v = 0; v < NUM_VNS; v++) begin : g_lbdr_out
    assign lbdr_bits_o[v] = lbdr_bits_t'(regs_q[v][LBDR_W-1:0]);
  end

endmodule

//--- design/cfg_response_buffer.sv
/*
  One-entry holding register for read responses.
  Loads at the accepting edge of a read and holds under back-pressure.
  A response taken at the same edge as a new read is replaced with no gap,
  so reads run at full rate while rsp_ready_i stays high.
*/
module cfg_response_buffer
  import cfg_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 rd_en_i,
  input  logic [NODE_ID_W-1:0] source_id_i,
  input  logic [ENTRY_W-1:0]   rd_data_i,
  input  logic                 rsp_ready_i,
  output logic                 rsp_valid_o,
  output cfg_rsp_t             rsp_data_o,
  output logic                 rsp_stall_o
);

  logic     valid_q;
  cfg_rsp_t data_q;

  // ------------------------------
  // valid flag
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (rd_en_i) begin
      // new read, either slot empty or old response leaving now
      valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // ------------------------------
  // payload
  // ------------------------------
  // decoder never strobes rd_en_i while stalled, so no overwrite of a held response
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      data_q <= '{source_id: source_id_i, data: rd_data_i};
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_data_o  = data_q;

  // held and not leaving this cycle
  assign rsp_stall_o = valid_q && !rsp_ready_i;

endmodule

//--- design/cfg_regbank_top.sv
/*
  Configuration register bank of a mesh NoC router.
  Command and response ports are valid/ready streams, no tlast.
  NUM_VNS must be 1..MAX_VNS. NODE_ID gives x in the low COORD_W bits,
  y in the next COORD_W bits. One read response may be pending.
*/
module cfg_regbank_top
  import cfg_pkg::*, lbdr_pkg::*;
#(
  parameter int unsigned NODE_ID   = 0,
  parameter int unsigned MESH_COLS = 1,
  parameter int unsigned MESH_ROWS = 1,
  parameter int unsigned NUM_VNS   = 1,
  parameter int unsigned CSR_VN_ID = 0
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // command stream
  input  logic                     cmd_valid_i,
  input  cfg_cmd_t                 cmd_data_i,
  output logic                     cmd_ready_o,
  // response stream
  output logic                     rsp_valid_o,
  output cfg_rsp_t                 rsp_data_o,
  input  logic                     rsp_ready_i,
  // per-VN routing config to the router
  output lbdr_bits_t [NUM_VNS-1:0] lbdr_bits_o
);

  // VN entries must stay clear of the csr entry
  if (NUM_VNS < 1 || NUM_VNS > MAX_VNS) begin : g_bad_num_vns
    $error("NUM_VNS out of range 1..MAX_VNS");
  end

  logic                  rsp_stall;
  logic                  wr_en;
  logic                  rd_en;
  logic [ENTRY_ID_W-1:0] entry;
  logic [ENTRY_W-1:0]    payload;
  logic [ENTRY_W-1:0]    rd_data;

  // ------------------------------
  // command side
  // ------------------------------
  cfg_cmd_decoder u_decoder (
    .cmd_valid_i (cmd_valid_i),
    .cmd_data_i  (cmd_data_i),
    .rsp_stall_i (rsp_stall),
    .cmd_ready_o (cmd_ready_o),
    .wr_en_o     (wr_en),
    .rd_en_o     (rd_en),
    .entry_o     (entry),
    .payload_o   (payload)
  );

  // ------------------------------
  // storage
  // ------------------------------
  cfg_register_bank #(
    .NODE_ID   (NODE_ID),
    .MESH_COLS (MESH_COLS),
    .MESH_ROWS (MESH_ROWS),
    .NUM_VNS   (NUM_VNS),
    .CSR_VN_ID (CSR_VN_ID)
  ) u_bank (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_en_i     (wr_en),
    .entry_i     (entry),
    .payload_i   (payload),
    .rd_data_o   (rd_data),
    .lbdr_bits_o (lbdr_bits_o)
  );

  // ------------------------------
  // response side
  // ------------------------------
  // source id rides in the low payload bits of a read
  cfg_response_buffer u_rsp_buf (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_en_i     (rd_en),
    .source_id_i (payload[NODE_ID_W-1:0]),
    .rd_data_i   (rd_data),
    .rsp_ready_i (rsp_ready_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_stall_o (rsp_stall)
  );

endmodule

//--- sim/cfg_regbank_checker.sv
/*
  Stream protocol assertions for cfg_regbank_top, attached by bind.
  Only one response can be pending, so a read must wait while it is held.
*/
module cfg_regbank_checker
  import cfg_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  input logic     cmd_valid_i,
  input cfg_cmd_t cmd_data_i,
  input logic     cmd_ready_o,
  input logic     rsp_valid_o,
  input cfg_rsp_t rsp_data_o,
  input logic     rsp_ready_i
);

  // held response keeps valid and data until taken
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o))
    else $error("response changed while held");

  // no second read may enter behind a stuck response
  a_read_gate: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i && cmd_valid_i && cmd_data_i.opcode == CMD_READ
    |-> !cmd_ready_o)
    else $error("read accepted while a response was held");

  a_reset_idle: assert property (@(posedge clk_i) rst_i |=> !rsp_valid_o)
    else $error("response valid right after reset");

endmodule

bind cfg_regbank_top cfg_regbank_checker i_checker (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .cmd_valid_i (cmd_valid_i),
  .cmd_data_i  (cmd_data_i),
  .cmd_ready_o (cmd_ready_o),
  .rsp_valid_o (rsp_valid_o),
  .rsp_data_o  (rsp_data_o),
  .rsp_ready_i (rsp_ready_i)
);

//--- sim/tb_cfg_regbank.sv
/*
  Directed testbench of the configuration register bank.
  Node 0x10 (x 0, y 1) in a 4x3 mesh, 3 VNs, CSR VN id 2.
  Inputs change 1 unit after the rising edge, outputs are sampled
  on the falling edge. The run stops at the first mismatch.
*/
module tb_cfg_regbank
  import cfg_pkg::*, lbdr_pkg::*;
;

  localparam int unsigned NODE_ID   = 'h10;
  localparam int unsigned MESH_COLS = 4;
  localparam int unsigned MESH_ROWS = 3;
  localparam int unsigned NUM_VNS   = 3;
  localparam int unsigned CSR_VN_ID = 2;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int STREAM_READS    = 6;

  // x 0, y 1 of 4x3: xy turns ren res rwn rws, links north east south, none west
  localparam logic [ENTRY_W-1:0] VN_RST = 32'h0000_03cd;

  logic                     clk_i;
  logic                     rst_i;
  logic                     cmd_valid_i;
  cfg_cmd_t                 cmd_data_i;
  logic                     cmd_ready_o;
  logic                     rsp_valid_o;
  cfg_rsp_t                 rsp_data_o;
  logic                     rsp_ready_i;
  lbdr_bits_t [NUM_VNS-1:0] lbdr_bits_o;

  // expected register contents
  logic [ENTRY_W-1:0] model [NUM_ENTRIES];
  logic [31:0]        lcg_state;

  cfg_regbank_top #(
    .NODE_ID   (NODE_ID),
    .MESH_COLS (MESH_COLS),
    .MESH_ROWS (MESH_ROWS),
    .NUM_VNS   (NUM_VNS),
    .CSR_VN_ID (CSR_VN_ID)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_ready_o (cmd_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_ready_i (rsp_ready_i),
    .lbdr_bits_o (lbdr_bits_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, got);
      $display("** FAIL **");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic drive_cmd(input cfg_opcode_e op, input int e, input logic [ENTRY_W-1:0] p);
    cmd_valid_i = 1'b1;
    cmd_data_i  = '{opcode: op, entry: e[ENTRY_ID_W-1:0], payload: p};
  endtask

  // holds the command until the DUT takes it
  task automatic send_cmd(input cfg_opcode_e op, input int e, input logic [ENTRY_W-1:0] p);
    drive_cmd(op, e, p);
    @(negedge clk_i);
    while (!cmd_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b0;
  endtask

  task automatic expect_rsp(input logic [NODE_ID_W-1:0] src, input logic [ENTRY_W-1:0] data);
    @(negedge clk_i);
    while (!rsp_valid_o) @(negedge clk_i);
    check_eq("rsp_data_o.source_id", 32'(src), 32'(rsp_data_o.source_id));
    check_eq("rsp_data_o.data", data, rsp_data_o.data);
    @(posedge clk_i);
    #1;
  endtask

  task automatic read_check(input int e, input logic [NODE_ID_W-1:0] src);
    send_cmd(CMD_READ, e, ENTRY_W'(src));
    expect_rsp(src, model[e]);
  endtask

  task automatic read_all();
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      read_check(e, 8'(lcg_next()));
    end
  endtask

  task automatic check_lbdr_all();
    for (int v = 0; v < NUM_VNS; v++) begin
      check_eq("lbdr_bits_o", 32'(model[v][LBDR_W-1:0]), 32'(lbdr_bits_o[v]));
    end
  endtask

  // the command just taken must leave the response side idle
  task automatic check_no_rsp();
    @(negedge clk_i);
    check_eq("rsp_valid_o", 32'(1'b0), 32'(rsp_valid_o));
    check_lbdr_all();
    @(posedge clk_i);
    #1;
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset_defaults();
    check_lbdr_all();
    read_all();
  endtask

  task automatic test_write_readback();
    logic [ENTRY_W-1:0] d;
    for (int e = 0; e < CSR_VN_ENTRY; e++) begin
      d = lcg_next();
      send_cmd(CMD_WRITE, e, d);
      model[e] = d;
      // new bits visible in the cycle after the accepting edge
      check_lbdr_all();
    end
    read_all();
  endtask

  task automatic test_protect_nop();
    send_cmd(CMD_WRITE, CSR_VN_ENTRY, lcg_next());
    send_cmd(CMD_NOP, 3, lcg_next());
    check_no_rsp();
    send_cmd(CMD_RSVD, 4, lcg_next());
    check_no_rsp();
    read_check(CSR_VN_ENTRY, 8'h3c);
    read_check(3, 8'h33);
    read_check(4, 8'h44);
  endtask

  task automatic test_backpressure();
    logic [ENTRY_W-1:0] old_a;
    logic [ENTRY_W-1:0] d;
    rsp_ready_i = 1'b0;
    old_a = model[1];
    send_cmd(CMD_READ, 1, 32'h5a);
    // writes still pass while read A is held, one of them to A's entry
    d = lcg_next();
    send_cmd(CMD_WRITE, 1, d);
    model[1] = d;
    d = lcg_next();
    send_cmd(CMD_WRITE, 6, d);
    model[6] = d;
    drive_cmd(CMD_READ, 1, 32'ha5);
    repeat (3) begin
      @(negedge clk_i);
      check_eq("cmd_ready_o", 32'(1'b0), 32'(cmd_ready_o));
      check_eq("rsp_valid_o", 32'(1'b1), 32'(rsp_valid_o));
      check_eq("rsp_data_o.data", old_a, rsp_data_o.data);
    end
    @(posedge clk_i);
    #1;
    rsp_ready_i = 1'b1;
    // A leaves at the same edge that takes read B
    expect_rsp(8'h5a, old_a);
    cmd_valid_i = 1'b0;
    expect_rsp(8'ha5, model[1]);
  endtask

  task automatic test_streaming();
    logic [NODE_ID_W-1:0] src_n;
    logic [NODE_ID_W-1:0] src_q;
    logic [ENTRY_W-1:0]   data_q;
    int                   e;
    src_n  = '0;
    src_q  = '0;
    data_q = '0;
    e      = 0;
    for (int k = 0; k <= STREAM_READS; k++) begin
      if (k < STREAM_READS) begin
        e     = lcg_next() & 32'hf;
        src_n = 8'(lcg_next());
        drive_cmd(CMD_READ, e, ENTRY_W'(src_n));
      end else begin
        cmd_valid_i = 1'b0;
      end
      @(negedge clk_i);
      if (k < STREAM_READS) begin
        check_eq("cmd_ready_o", 32'(1'b1), 32'(cmd_ready_o));
      end
      // previous read answers exactly one cycle after its acceptance
      if (k > 0) begin
        check_eq("rsp_valid_o", 32'(1'b1), 32'(rsp_valid_o));
        check_eq("rsp_data_o.source_id", 32'(src_q), 32'(rsp_data_o.source_id));
        check_eq("rsp_data_o.data", data_q, rsp_data_o.data);
      end
      src_q  = src_n;
      data_q = model[e];
      @(posedge clk_i);
      #1;
    end
    @(negedge clk_i);
    check_eq("rsp_valid_o", 32'(1'b0), 32'(rsp_valid_o));
    @(posedge clk_i);
    #1;
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial begin
    rst_i       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_data_i  = '0;
    rsp_ready_i = 1'b1;
    lcg_state   = 32'ha183;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      model[e] = (e < NUM_VNS) ? VN_RST : '0;
    end
    model[CSR_VN_ENTRY] = ENTRY_W'(CSR_VN_ID);
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_eq("rsp_valid_o", 32'(1'b0), 32'(rsp_valid_o));
    check_eq("cmd_ready_o", 32'(1'b1), 32'(cmd_ready_o));
    @(posedge clk_i);
    #1;
    test_reset_defaults();
    test_write_readback();
    test_protect_nop();
    test_backpressure();
    test_streaming();
    $display("** PASS **");
    $finish;
  end

  initial begin
    repeat (16 + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_i);
    $display("watchdog expired, a handshake never completed");
    $display("** FAIL **");
    $fatal(1, "timeout");
  end

endmodule

//--- tb.f
design/cfg_pkg.sv
design/lbdr_pkg.sv
design/cfg_cmd_decoder.sv
design/cfg_register_bank.sv
design/cfg_response_buffer.sv
design/cfg_regbank_top.sv
sim/cfg_regbank_checker.sv
sim/tb_cfg_regbank.sv

//--- run.sh
#!/bin/sh
# build and run the register bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module tb_cfg_regbank -o tb_cfg_regbank
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_cfg_regbank
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0
